// ==== hw/tilemapPkg.sv ====
`default_nettype none

package tilemapPkg;

	//////////////////////////////
	// plain vector types
	//////////////////////////////

	// raster position, horizontal or vertical
	typedef logic [8:0] pixelCount_t;

	// tile RAM address
	// {layer, row[4:0], column[5:0], byte select}
	typedef logic [12:0] tileRamAddr_t;

	// one tile RAM byte
	typedef logic [7:0] tileByte_t;

	// tile ROM address
	// {attr[1:0], index[7:0], tile row[2:0], nibble}
	typedef logic [13:0] romAddr_t;

	//////////////////////////////
	// bundles
	//////////////////////////////

	// one CPU access, held stable while req is high
	typedef struct packed {
		logic         write;
		// scroll registers instead of RAM
		logic         isScroll;
		// RAM address, or scroll select in bits 2:0
		tileRamAddr_t addr;
		tileByte_t    wdata;
	} cpuReq_t;

	// scroll and priority of one layer
	typedef struct packed {
		logic [8:0] hOffset;
		logic [7:0] vOffset;
		logic [2:0] pri;
	} layerScroll_t;

	// one completed tile fetch
	typedef struct packed {
		logic     layer;
		romAddr_t addr;
	} romFetch_t;

endpackage

`default_nettype wire

// ==== hw/videoTiming.sv ====
`timescale 1ns/10ps
`default_nettype none

module videoTiming #(
	parameter int H_TOTAL = 384,
	parameter int V_TOTAL = 264
) (
	input  wire                     CLK_6M,
	input  wire                     rst,
	output tilemapPkg::pixelCount_t hCount,
	output tilemapPkg::pixelCount_t vCount,
	output logic                    frameStart,
	output logic                    hsync,
	output logic                    vsync
);
	import tilemapPkg::*;

	// last count of each axis
	localparam pixelCount_t H_LAST = pixelCount_t'(H_TOTAL - 1);
	localparam pixelCount_t V_LAST = pixelCount_t'(V_TOTAL - 1);
	// sync pulse widths, in counts from the origin
	localparam pixelCount_t HSYNC_END = pixelCount_t'(32);
	localparam pixelCount_t VSYNC_END = pixelCount_t'(8);

	logic lineEnd;

	assign lineEnd = (hCount == H_LAST);

	// raster counters, v steps on the last pixel of a line
	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			if (vCount == V_LAST)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	// decodes, held low during reset
	assign frameStart = ~rst & (hCount == '0) & (vCount == '0);
	assign hsync = ~rst & (hCount < HSYNC_END);
	assign vsync = ~rst & (vCount < VSYNC_END);

	// h stays in range and only counts up by one or wraps to 0
	property hCountSteps;
		@(posedge CLK_6M) disable iff (rst)
			(hCount < H_TOTAL) && ((hCount == '0) || (hCount == $past(hCount) + 1'b1));
	endproperty
	assert property (hCountSteps)
		else $error("hCount left the raster");

endmodule

`default_nettype wire

// ==== hw/scrollRegs.sv ====
`timescale 1ns/10ps
`default_nettype none

module scrollRegs #(
	parameter int AUTOSCROLL_A = 0,
	parameter int AUTOSCROLL_B = 0
) (
	input  wire                        CLK_6M,
	input  wire                        rst,
	input  wire                        frameStart,
	input  wire                        scrollWe,
	input  wire [2:0]                  scrollSel,
	input  wire tilemapPkg::tileByte_t scrollWdata,
	output tilemapPkg::tileByte_t      pendingRdata,
	output tilemapPkg::layerScroll_t   activeScrollA,
	output tilemapPkg::layerScroll_t   activeScrollB
);
	import tilemapPkg::*;

	// per-frame horizontal drift modulo 512
	localparam pixelCount_t STEP_A = pixelCount_t'(AUTOSCROLL_A);
	localparam pixelCount_t STEP_B = pixelCount_t'(AUTOSCROLL_B);

	// index 0 is layer A and 1 is layer B
	layerScroll_t pending [2];
	layerScroll_t active [2];
	pixelCount_t  autoAcc [2];
	layerScroll_t selLayer;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			for (int i = 0; i < 2; i++) begin
				pending[i] <= '0;
				active[i] <= '0;
				autoAcc[i] <= '0;
			end
		end else begin
			// byte lanes with sel bit 2 picking the layer
			if (scrollWe) begin
				case (scrollSel[1:0])
					2'd0: pending[scrollSel[2]].hOffset[7:0] <= scrollWdata;
					2'd1: begin
						pending[scrollSel[2]].hOffset[8] <= scrollWdata[0];
						pending[scrollSel[2]].pri <= scrollWdata[3:1];
					end
					2'd2: pending[scrollSel[2]].vOffset <= scrollWdata;
					default: ;
				endcase
			end
			// frame start commit sees pending from before this edge
			if (frameStart) begin
				for (int i = 0; i < 2; i++) begin
					active[i] <= '{
						hOffset: pending[i].hOffset + autoAcc[i],
						vOffset: pending[i].vOffset,
						pri: pending[i].pri
					};
					autoAcc[i] <= autoAcc[i] + ((i == 0) ? STEP_A : STEP_B);
				end
			end
		end
	end

	// pending readback uses the write lane layout
	assign selLayer = pending[scrollSel[2]];

	always_comb begin
		case (scrollSel[1:0])
			2'd0: pendingRdata = selLayer.hOffset[7:0];
			2'd1: pendingRdata = {4'b0000, selLayer.pri, selLayer.hOffset[8]};
			2'd2: pendingRdata = selLayer.vOffset;
			default: pendingRdata = '0;
		endcase
	end

	assign activeScrollA = active[0];
	assign activeScrollB = active[1];

endmodule

`default_nettype wire

// ==== hw/tileRam.sv ====
`timescale 1ns/10ps
`default_nettype none

module tileRam (
	input  wire                           CLK_6M,
	input  wire tilemapPkg::tileRamAddr_t ramCpuAddr,
	input  wire                           ramCpuWe,
	input  wire tilemapPkg::tileByte_t    ramCpuWdata,
	input  wire tilemapPkg::tileRamAddr_t ramVidAddr,
	output tilemapPkg::tileByte_t         ramCpuRdata,
	output tilemapPkg::tileByte_t         ramVidRdata
);
	import tilemapPkg::*;

	// two maps of 64x32 tiles, two bytes each
	localparam int DEPTH = 2 ** $bits(tileRamAddr_t);

	tileByte_t mem [DEPTH];

	//////////////////////////////
	// CPU port, read and write
	//////////////////////////////

	// read returns the old byte on a same-address write
	always_ff @(posedge CLK_6M) begin
		if (ramCpuWe)
			mem[ramCpuAddr] <= ramCpuWdata;
		ramCpuRdata <= mem[ramCpuAddr];
	end

	//////////////////////////////
	// video port, read only
	//////////////////////////////

	// one cycle behind the fetch address
	always_ff @(posedge CLK_6M) begin
		ramVidRdata <= mem[ramVidAddr];
	end

endmodule

`default_nettype wire

// ==== hw/cpuPort.sv ====
`timescale 1ns/10ps
`default_nettype none

module cpuPort (
	input  wire                        CLK_6M,
	input  wire                        rst,
	input  wire                        cpuReqValid,
	input  wire tilemapPkg::cpuReq_t   cpuReq,
	input  wire tilemapPkg::tileByte_t ramCpuRdata,
	input  wire tilemapPkg::tileByte_t pendingRdata,
	output logic                       cpuAck,
	output tilemapPkg::tileByte_t      cpuRdata,
	output tilemapPkg::tileRamAddr_t   ramCpuAddr,
	output logic                       ramCpuWe,
	output tilemapPkg::tileByte_t      ramCpuWdata,
	output logic                       scrollWe,
	output logic [2:0]                 scrollSel,
	output tilemapPkg::tileByte_t      scrollWdata
);
	typedef enum logic [1:0] {idle, access, waitData, ackHigh} portState_t;

	portState_t state;
	logic       ramRead;

	// RAM reads need the extra cycle for registered data
	assign ramRead = !cpuReq.write && !cpuReq.isScroll;

	always_ff @(posedge CLK_6M) begin
		if (rst) begin
			state <= idle;
			cpuAck <= 1'b0;
		end else begin
			case (state)
				idle: begin
					if (cpuReqValid)
						state <= access;
				end
				access: begin
					if (ramRead) begin
						state <= waitData;
					end else begin
						state <= ackHigh;
						cpuAck <= 1'b1;
					end
				end
				waitData: begin
					state <= ackHigh;
					cpuAck <= 1'b1;
				end
				ackHigh: begin
					// master dropped req, release ack
					if (!cpuReqValid) begin
						state <= idle;
						cpuAck <= 1'b0;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// read data, held through ack high
	always_ff @(posedge CLK_6M) begin
		if (state == access && cpuReq.isScroll)
			cpuRdata <= pendingRdata;
		else if (state == waitData)
			cpuRdata <= ramCpuRdata;
	end

	// request fields are stable while req is up
	assign ramCpuAddr = cpuReq.addr;
	assign ramCpuWdata = cpuReq.wdata;
	assign scrollSel = cpuReq.addr[2:0];
	assign scrollWdata = cpuReq.wdata;
	// strobes only in the access cycle
	assign ramCpuWe = (state == access) && cpuReq.write && !cpuReq.isScroll;
	assign scrollWe = (state == access) && cpuReq.write && cpuReq.isScroll;

	assert property (@(posedge CLK_6M) disable iff (rst) $rose(cpuAck) |-> cpuReqValid)
		else $error("cpuAck rose without a request");
	assert property (@(posedge CLK_6M) disable iff (rst) ramCpuWe |=> !ramCpuWe)
		else $error("ramCpuWe held for more than one cycle");

endmodule

`default_nettype wire

// ==== hw/tilemapAddrGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tilemapAddrGen (
	input  wire                           CLK_6M,
	input  wire                           rst,
	input  wire tilemapPkg::pixelCount_t  hCount,
	input  wire tilemapPkg::pixelCount_t  vCount,
	input  wire tilemapPkg::layerScroll_t activeScrollA,
	input  wire tilemapPkg::layerScroll_t activeScrollB,
	input  wire tilemapPkg::tileByte_t    ramVidRdata,
	output tilemapPkg::tileRamAddr_t      ramVidAddr,
	output tilemapPkg::romFetch_t         romFetch,
	output logic                          romValid
);
	import tilemapPkg::*;

	// what a RAM read was issued for, travels one cycle with it
	typedef struct packed {
		logic       layer;
		logic       byteSel;
		logic [2:0] tileRow;
		logic       nibble;
	} fetchTag_t;

	logic         layer;
	logic         byteSel;
	pixelCount_t  slotBase;
	layerScroll_t scroll;
	pixelCount_t  sh;
	logic [7:0]   sv;
	fetchTag_t    tagQ;
	tileByte_t    indexQ;

	//////////////////////////////
	// slot decode and scroll add
	//////////////////////////////

	// slot order A0 A1 B0 B1
	assign layer = hCount[1];
	assign byteSel = hCount[0];
	// both bytes of a layer share one column
	assign slotBase = {hCount[8:2], 2'b00};
	assign scroll = layer ? activeScrollB : activeScrollA;

	// wraps at 512 and 256
	assign sh = scroll.hOffset + slotBase;
	assign sv = scroll.vOffset + vCount[7:0];

	// map row from sv, map column from sh
	assign ramVidAddr = {layer, sv[7:3], sh[8:3], byteSel};

	//////////////////////////////
	// capture pipeline
	//////////////////////////////

	// stage 1, tag lines up with ramVidRdata
	always_ff @(posedge CLK_6M) begin
		if (rst)
			tagQ <= '0;
		else
			tagQ <= '{layer: layer, byteSel: byteSel, tileRow: sv[2:0], nibble: sh[2]};
	end

	// byte 0 is the tile index
	always_ff @(posedge CLK_6M) begin
		if (!tagQ.byteSel)
			indexQ <= ramVidRdata;
	end

	// stage 2, byte 1 completes the fetch
	always_ff @(posedge CLK_6M) begin
		if (rst)
			romValid <= 1'b0;
		else
			romValid <= tagQ.byteSel;
	end

	// attr low bits, index, row in tile, half of the row
	always_ff @(posedge CLK_6M) begin
		if (tagQ.byteSel) begin
			romFetch.layer <= tagQ.layer;
			romFetch.addr <= {ramVidRdata[1:0], indexQ, tagQ.tileRow, tagQ.nibble};
		end
	end

	// every second cycle a fetch, layers take turns
	property layersAlternate;
		@(posedge CLK_6M) disable iff (rst)
			$past(romValid, 2) |-> romValid && (romFetch.layer != $past(romFetch.layer, 2));
	endproperty
	assert property (layersAlternate)
		else $error("romValid pulses out of layer order");

endmodule

`default_nettype wire

// ==== hw/tilemapTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module tilemapTop #(
	parameter int H_TOTAL      = 384,
	parameter int V_TOTAL      = 264,
	parameter int AUTOSCROLL_A = 0,
	parameter int AUTOSCROLL_B = 0
) (
	input  wire                      CLK_6M,
	input  wire                      rst,
	input  wire                      cpuReqValid,
	input  wire tilemapPkg::cpuReq_t cpuReq,
	output logic                     cpuAck,
	output tilemapPkg::tileByte_t    cpuRdata,
	output logic                     hsync,
	output logic                     vsync,
	output tilemapPkg::pixelCount_t  hCount,
	output tilemapPkg::pixelCount_t  vCount,
	output tilemapPkg::layerScroll_t activeScrollA,
	output tilemapPkg::layerScroll_t activeScrollB,
	output tilemapPkg::romFetch_t    romFetch,
	output logic                     romValid
);
	import tilemapPkg::*;

	logic         frameStart;
	// CPU side of the tile RAM
	tileRamAddr_t ramCpuAddr;
	logic         ramCpuWe;
	tileByte_t    ramCpuWdata;
	tileByte_t    ramCpuRdata;
	// video side of the tile RAM
	tileRamAddr_t ramVidAddr;
	tileByte_t    ramVidRdata;
	// scroll register access
	logic         scrollWe;
	logic [2:0]   scrollSel;
	tileByte_t    scrollWdata;
	tileByte_t    pendingRdata;

	videoTiming #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) uTiming (
		.CLK_6M(CLK_6M), .rst(rst),
		.hCount(hCount), .vCount(vCount), .frameStart(frameStart),
		.hsync(hsync), .vsync(vsync)
	);

	scrollRegs #(.AUTOSCROLL_A(AUTOSCROLL_A), .AUTOSCROLL_B(AUTOSCROLL_B)) uScroll (
		.CLK_6M(CLK_6M), .rst(rst), .frameStart(frameStart),
		.scrollWe(scrollWe), .scrollSel(scrollSel), .scrollWdata(scrollWdata),
		.pendingRdata(pendingRdata),
		.activeScrollA(activeScrollA), .activeScrollB(activeScrollB)
	);

	tileRam uRam (
		.CLK_6M(CLK_6M),
		.ramCpuAddr(ramCpuAddr), .ramCpuWe(ramCpuWe), .ramCpuWdata(ramCpuWdata),
		.ramVidAddr(ramVidAddr),
		.ramCpuRdata(ramCpuRdata), .ramVidRdata(ramVidRdata)
	);

	cpuPort uCpu (
		.CLK_6M(CLK_6M), .rst(rst),
		.cpuReqValid(cpuReqValid), .cpuReq(cpuReq),
		.ramCpuRdata(ramCpuRdata), .pendingRdata(pendingRdata),
		.cpuAck(cpuAck), .cpuRdata(cpuRdata),
		.ramCpuAddr(ramCpuAddr), .ramCpuWe(ramCpuWe), .ramCpuWdata(ramCpuWdata),
		.scrollWe(scrollWe), .scrollSel(scrollSel), .scrollWdata(scrollWdata)
	);

	tilemapAddrGen uAddrGen (
		.CLK_6M(CLK_6M), .rst(rst),
		.hCount(hCount), .vCount(vCount),
		.activeScrollA(activeScrollA), .activeScrollB(activeScrollB),
		.ramVidRdata(ramVidRdata), .ramVidAddr(ramVidAddr),
		.romFetch(romFetch), .romValid(romValid)
	);

endmodule

`default_nettype wire

// ==== bench/tbTilemapTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbTilemapTop;
	import tilemapPkg::*;

	localparam int H_TOTAL = 384;
	localparam int V_TOTAL = 264;
	localparam int AUTO_A = 1;
	localparam int AUTO_B = 0;
	localparam pixelCount_t STEP_A = pixelCount_t'(AUTO_A);
	localparam pixelCount_t STEP_B = pixelCount_t'(AUTO_B);
	// sync pulses counted from the raster origin
	localparam int HSYNC_WIDTH = 32;
	localparam int VSYNC_WIDTH = 8;
	// five frames plus slack for reset and handshakes
	localparam int CYCLE_LIMIT = 5 * H_TOTAL * V_TOTAL + 2000;
	localparam int ACK_LIMIT = 20;

	logic         CLK_6M = 1'b0;
	logic         rst;
	logic         cpuReqValid;
	cpuReq_t      cpuReq;
	logic         cpuAck;
	tileByte_t    cpuRdata;
	logic         hsync;
	logic         vsync;
	pixelCount_t  hCount;
	pixelCount_t  vCount;
	layerScroll_t activeScrollA;
	layerScroll_t activeScrollB;
	romFetch_t    romFetch;
	logic         romValid;

	// reference model state
	tileByte_t    mirror [8192];
	layerScroll_t modelPending [2];
	layerScroll_t modelActive [2];
	pixelCount_t  autoAcc [2];
	romFetch_t    expFetches [$];
	romFetch_t    expFetch;
	romFetch_t    nextFetch;
	tileByte_t    indexByte;
	logic         fetchCheck = 1'b0;
	logic         lastLayer;
	logic         haveLayer;
	logic         rasterLive;
	int           prevH;
	int           prevV;
	int           expH;
	int           expV;
	int           fetchCount = 0;
	// working values of the fetch prediction
	logic         layerSel;
	pixelCount_t  sh;
	logic [7:0]   sv;
	tileRamAddr_t vidAddr;

	int seed = 32'h4bba;
	int errors = 0;
	int checks = 0;
	int testsRun = 0;
	int cycleCount = 0;

	tilemapTop #(
		.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .AUTOSCROLL_A(AUTO_A), .AUTOSCROLL_B(AUTO_B)
	) u_dut (
		.CLK_6M(CLK_6M), .rst(rst), .cpuReqValid(cpuReqValid), .cpuReq(cpuReq),
		.cpuAck(cpuAck), .cpuRdata(cpuRdata), .hsync(hsync), .vsync(vsync),
		.hCount(hCount), .vCount(vCount),
		.activeScrollA(activeScrollA), .activeScrollB(activeScrollB),
		.romFetch(romFetch), .romValid(romValid)
	);

	always #10 CLK_6M = ~CLK_6M;

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Mismatch at %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic finishRun();
		$display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	endtask

	task automatic reportTest(input int num, input string name, input int errStart);
		testsRun++;
		$display("test %0d, %s: %0d errors", num, name, errors - errStart);
	endtask

	//////////////////////////////
	// CPU side helpers
	//////////////////////////////

	// one four-phase access started on a rising edge
	task automatic cpuAccess(input logic wr, input logic scr, input tileRamAddr_t addr,
			input tileByte_t wdata, output tileByte_t rdata);
		int waited;
		int latency;
		waited = 0;
		rdata = '0;
		// RAM reads take one cycle more for the registered data
		latency = (!wr && !scr) ? 4 : 3;
		cpuReq <= '{write: wr, isScroll: scr, addr: addr, wdata: wdata};
		cpuReqValid <= 1'b1;
		do begin
			@(posedge CLK_6M);
			waited++;
		end while (!cpuAck && waited < ACK_LIMIT);
		if (!cpuAck) begin
			errors++;
			$display("CPU handshake hung at %0t: no ack for address %h", $time, addr);
		end else begin
			rdata = cpuRdata;
			check(waited, latency, "ack latency");
		end
		cpuReqValid <= 1'b0;
		waited = 0;
		do begin
			@(posedge CLK_6M);
			waited++;
		end while (cpuAck && waited < ACK_LIMIT);
		if (cpuAck) begin
			errors++;
			$display("CPU handshake hung at %0t: ack stayed high after req dropped", $time);
		end
	endtask

	// register map applied to the model's pending set
	task automatic applyScrollWrite(input logic [2:0] sel, input tileByte_t d);
		case (sel[1:0])
			2'd0: modelPending[sel[2]].hOffset[7:0] = d;
			2'd1: begin
				modelPending[sel[2]].hOffset[8] = d[0];
				modelPending[sel[2]].pri = d[3:1];
			end
			2'd2: modelPending[sel[2]].vOffset = d;
			default: ;
		endcase
	endtask

	function automatic tileByte_t scrollReadback(input logic [2:0] sel);
		layerScroll_t s;
		s = modelPending[sel[2]];
		case (sel[1:0])
			2'd0: return s.hOffset[7:0];
			2'd1: return {4'b0000, s.pri, s.hOffset[8]};
			2'd2: return s.vOffset;
			default: return '0;
		endcase
	endfunction

	// keep scroll writes well away from the commit
	task automatic waitScrollWindow();
		while (!(vCount >= 16 && vCount < 240))
			@(posedge CLK_6M);
	endtask

	// returns one cycle after the frame start edge
	task automatic waitFrameStart();
		do
			@(posedge CLK_6M);
		while (!(hCount == '0 && vCount == '0));
		@(posedge CLK_6M);
	endtask

	//////////////////////////////
	// monitor and model
	//////////////////////////////

	always @(posedge CLK_6M) begin
		if (rst) begin
			rasterLive = 1'b0;
			haveLayer = 1'b0;
			expFetches.delete();
			for (int i = 0; i < 2; i++) begin
				modelActive[i] = '0;
				autoAcc[i] = '0;
			end
		end else begin
			// raster steps by one and wraps
			if (rasterLive) begin
				expH = (prevH == H_TOTAL - 1) ? 0 : prevH + 1;
				expV = prevV;
				if (prevH == H_TOTAL - 1)
					expV = (prevV == V_TOTAL - 1) ? 0 : prevV + 1;
				check(hCount, expH, "hCount step");
				check(vCount, expV, "vCount step");
			end
			rasterLive = 1'b1;
			prevH = hCount;
			prevV = vCount;
			// sync decodes against the raster position
			check(hsync, hCount < HSYNC_WIDTH, "hsync decode");
			check(vsync, vCount < VSYNC_WIDTH, "vsync decode");
			// completed fetch against the oldest prediction
			if (romValid) begin
				if (expFetches.size() == 0) begin
					errors++;
					$display("romValid pulsed at %0t with no fetch outstanding", $time);
				end else begin
					expFetch = expFetches.pop_front();
					check(romFetch.layer, expFetch.layer, "fetch layer");
					if (fetchCheck) begin
						check(romFetch.addr, expFetch.addr, "fetch ROM address");
						fetchCount <= fetchCount + 1;
					end
					if (haveLayer)
						check(romFetch.layer, !lastLayer, "layer alternation");
					lastLayer = romFetch.layer;
					haveLayer = 1'b1;
				end
			end
			// slot order A0 A1 B0 B1 with scroll added to the slot base
			layerSel = hCount[1];
			sh = modelActive[layerSel].hOffset + {hCount[8:2], 2'b00};
			sv = modelActive[layerSel].vOffset + vCount[7:0];
			vidAddr = {layerSel, sv[7:3], sh[8:3], hCount[0]};
			if (!hCount[0]) begin
				indexByte = mirror[vidAddr];
			end else begin
				nextFetch.layer = layerSel;
				nextFetch.addr = {mirror[vidAddr][1:0], indexByte, sv[2:0], sh[2]};
				expFetches.push_back(nextFetch);
			end
			// frame start commit then the autoscroll grows
			if (hCount == '0 && vCount == '0) begin
				for (int i = 0; i < 2; i++) begin
					modelActive[i].hOffset = modelPending[i].hOffset + autoAcc[i];
					modelActive[i].vOffset = modelPending[i].vOffset;
					modelActive[i].pri = modelPending[i].pri;
					autoAcc[i] = autoAcc[i] + ((i == 0) ? STEP_A : STEP_B);
				end
			end
		end
	end

	// run limit
	always @(posedge CLK_6M) begin
		cycleCount++;
		if (cycleCount >= CYCLE_LIMIT) begin
			errors++;
			$display("Run stopped: cycle limit of %0d reached before the tests ended", CYCLE_LIMIT);
			finishRun();
		end
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		tileByte_t    d;
		tileByte_t    rd;
		tileRamAddr_t a;
		logic [2:0]   sel;
		int           errStart;
		int           fetchStart;
		pixelCount_t  baseA;
		pixelCount_t  baseB;

		rst = 1'b1;
		cpuReqValid = 1'b0;
		cpuReq = '0;
		for (int i = 0; i < 2; i++)
			modelPending[i] = '0;

		// test 1 covers reset values and the first line wrap
		errStart = errors;
		repeat (4) @(posedge CLK_6M);
		check(cpuAck, 1'b0, "cpuAck in reset");
		check(romValid, 1'b0, "romValid in reset");
		check(hsync, 1'b0, "hsync in reset");
		check(vsync, 1'b0, "vsync in reset");
		check(activeScrollA, '0, "activeScrollA in reset");
		check(activeScrollB, '0, "activeScrollB in reset");
		rst <= 1'b0;
		do
			@(posedge CLK_6M);
		while (hCount != pixelCount_t'(H_TOTAL - 1));
		@(posedge CLK_6M);
		check(hCount, 0, "hCount after line wrap");
		check(vCount, 1, "vCount after line wrap");
		reportTest(1, "reset and raster", errStart);

		// test 2 fills the whole map then reads back at random
		errStart = errors;
		for (int i = 0; i < 8192; i++) begin
			d = tileByte_t'($random(seed));
			mirror[i] = d;
			cpuAccess(1'b1, 1'b0, tileRamAddr_t'(i), d, rd);
		end
		repeat (512) begin
			a = tileRamAddr_t'($random(seed));
			cpuAccess(1'b0, 1'b0, a, '0, rd);
			check(rd, mirror[a], "tile RAM readback");
		end
		reportTest(2, "tile RAM write and read", errStart);

		// test 3 covers pending writes, readback and the frame start commit
		errStart = errors;
		repeat (16) begin
			waitScrollWindow();
			sel = 3'($random(seed));
			d = tileByte_t'($random(seed));
			applyScrollWrite(sel, d);
			cpuAccess(1'b1, 1'b1, {10'b0, sel}, d, rd);
		end
		for (int i = 0; i < 8; i++) begin
			waitScrollWindow();
			cpuAccess(1'b0, 1'b1, {10'b0, 3'(i)}, '0, rd);
			check(rd, scrollReadback(3'(i)), "scroll register readback");
		end
		check(activeScrollA, modelActive[0], "layer A active before commit");
		check(activeScrollB, modelActive[1], "layer B active before commit");
		waitFrameStart();
		check(activeScrollA, modelActive[0], "layer A active after commit");
		check(activeScrollB, modelActive[1], "layer B active after commit");
		reportTest(3, "scroll registers", errStart);

		// test 4 compares every fetch of one frame
		errStart = errors;
		fetchCheck <= 1'b1;
		fetchStart = fetchCount;
		waitFrameStart();
		check(fetchCount - fetchStart > 0, 1'b1, "fetches seen in one frame");
		reportTest(4, "tile fetch frame", errStart);

		// test 5 follows the autoscroll over three frames
		errStart = errors;
		baseA = activeScrollA.hOffset;
		baseB = activeScrollB.hOffset;
		for (int k = 1; k <= 3; k++) begin
			waitFrameStart();
			check(activeScrollA.hOffset, baseA + pixelCount_t'(k), "layer A autoscroll");
			check(activeScrollB.hOffset, baseB, "layer B hOffset");
			check(activeScrollA, modelActive[0], "layer A active");
		end
		reportTest(5, "autoscroll", errStart);

		finishRun();
	end

endmodule

`default_nettype wire

// ==== tilemapTop.f ====
hw/tilemapPkg.sv
hw/videoTiming.sv
hw/scrollRegs.sv
hw/tileRam.sv
hw/cpuPort.sv
hw/tilemapAddrGen.sv
hw/tilemapTop.sv
bench/tbTilemapTop.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := tbTilemapTop
FILELIST  := tilemapTop.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
